// ==== snake.f ====
verilog/snake_geom_pkg.sv
verilog/snake_ctrl_pkg.sv
verilog/segment_ram.sv
verilog/heading_control.sv
verilog/body_sequencer.sv
verilog/plot_sequencer.sv
verilog/snake_top.sv
tests/clock_gen.sv
tests/snake_tb.sv

// ==== tests/clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
	output logic clock
);

	// half of the 10 ns period
	localparam int half_period = 5;

	initial begin
		clock = 1'b0;
		forever #half_period clock = ~clock;
	end

endmodule

`default_nettype wire

// ==== tests/snake_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module snake_tb;

	localparam int step_count = 200;
	localparam int step_cycles_worst = 60;
	localparam int init_cycles_worst = 100;
	localparam int timeout_cycles = 2 * (step_count * step_cycles_worst + init_cycles_worst);

	logic clock;
	logic reset_n;
	logic step_req;
	logic step_ack;
	snake_ctrl_pkg::heading_t turn;
	snake_ctrl_pkg::heading_t heading;
	snake_ctrl_pkg::pixel_t pixel;
	logic pixel_req;
	logic pixel_ack;

	integer seed;
	int errors;
	int checks;
	int cycle_count;
	snake_ctrl_pkg::pixel_t received[$];

	// reference model with the head at index 0
	int body_x[5];
	int body_y[5];
	logic [3:0] model_heading;
	int x_wraps;
	int y_wraps;

	logic prev_pixel_req;
	logic prev_pixel_ack;
	logic prev_step_req;
	logic prev_step_ack;
	snake_ctrl_pkg::pixel_t prev_pixel;

	clock_gen clock_gen_i (
		.clock(clock)
	);

	snake_top snake_top_i (
		.clock(clock),
		.reset_n(reset_n),
		.step_req(step_req),
		.step_ack(step_ack),
		.turn(turn),
		.heading(heading),
		.pixel(pixel),
		.pixel_req(pixel_req),
		.pixel_ack(pixel_ack)
	);

	task automatic compare_field(input string name, input int unsigned got,
		input int unsigned expected);
		checks++;
		assert (got == expected) else begin
			$display("error: %s expected %h got %h", name, expected, got);
			errors++;
		end
	endtask

	task automatic check_pixel(input snake_ctrl_pkg::pixel_t got, input int x, input int y,
		input int colour);
		compare_field("pixel.point.x", got.point.x, x);
		compare_field("pixel.point.y", got.point.y, y);
		compare_field("pixel.colour", got.colour, colour);
	endtask

	// drawn head crossing an edge of the coordinate space
	task automatic count_wraps(input int old_x, input int old_y,
		input snake_geom_pkg::point_t head);
		if ((old_x == 255 && head.x == 0) || (old_x == 0 && head.x == 255)) begin
			x_wraps++;
		end
		if ((old_y == 127 && head.y == 0) || (old_y == 0 && head.y == 127)) begin
			y_wraps++;
		end
	endtask

	// right and left lie on the x axis and down and up on the y axis
	function automatic logic [3:0] filter_turn(input logic [3:0] current,
		input logic [3:0] requested);
		logic [3:0] cross_axis;
		logic one_hot;
		cross_axis = ((current & 4'b1001) != 4'b0000) ? 4'b0110 : 4'b1001;
		one_hot = (requested != 4'b0000) && ((requested & (requested - 4'd1)) == 4'b0000);
		if (one_hot && ((requested & cross_axis) != 4'b0000)) begin
			return requested;
		end
		return current;
	endfunction

	task automatic advance_model(input logic [3:0] raw_turn);
		model_heading = filter_turn(model_heading, raw_turn);
		for (int i = 4; i > 0; i--) begin
			body_x[i] = body_x[i - 1];
			body_y[i] = body_y[i - 1];
		end
		case (model_heading)
			4'b0001: body_x[0] = (body_x[0] + 1) % 256;
			4'b1000: body_x[0] = (body_x[0] + 255) % 256;
			4'b0010: body_y[0] = (body_y[0] + 1) % 128;
			4'b0100: body_y[0] = (body_y[0] + 127) % 128;
			default: ;
		endcase
	endtask

	task automatic run_step(input int number, input logic [3:0] raw_turn);
		int gap;
		int old_tail_x;
		int old_tail_y;
		int old_head_x;
		int old_head_y;
		gap = $unsigned($random(seed)) % 8;
		repeat (gap) @(negedge clock);
		old_tail_x = body_x[4];
		old_tail_y = body_y[4];
		old_head_x = body_x[0];
		old_head_y = body_y[0];
		advance_model(raw_turn);
		turn = snake_ctrl_pkg::heading_t'(raw_turn);
		step_req = 1'b1;
		while (!step_ack) @(negedge clock);
		checks++;
		assert (received.size() == 2) else begin
			$display("step %0d produced %0d pixel transfers instead of two",
				number, received.size());
			errors++;
		end
		if (received.size() >= 1) check_pixel(received[0], old_tail_x, old_tail_y, 0);
		if (received.size() >= 2) begin
			check_pixel(received[1], body_x[0], body_y[0], 2);
			count_wraps(old_head_x, old_head_y, received[1].point);
		end
		received.delete();
		compare_field("heading", heading, model_heading);
		step_req = 1'b0;
		while (step_ack) @(negedge clock);
	endtask

	task automatic report_and_finish;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	// frame buffer with a random ack delay per transfer
	always begin
		int delay;
		@(negedge clock);
		if (reset_n && pixel_req && !pixel_ack) begin
			delay = $unsigned($random(seed)) % 6;
			repeat (delay) @(negedge clock);
			received.push_back(pixel);
			pixel_ack = 1'b1;
			do @(negedge clock); while (pixel_req);
			pixel_ack = 1'b0;
		end
	end

	// handshake rules against what the DUT saw at the last edge
	always @(posedge clock) begin
		if (reset_n) begin
			if (pixel_req && !prev_pixel_req) begin
				assert (!prev_pixel_ack) else begin
					$display("pixel_req rose while pixel_ack was still high");
					errors++;
				end
			end
			if (pixel_req && prev_pixel_req) begin
				assert (pixel == prev_pixel) else begin
					$display("error: pixel expected %h got %h", prev_pixel, pixel);
					errors++;
				end
			end
			if (step_ack && !prev_step_ack) begin
				assert (prev_step_req) else begin
					$display("step_ack rose while step_req was low");
					errors++;
				end
			end
		end
		prev_pixel_req = pixel_req;
		prev_pixel_ack = pixel_ack;
		prev_step_req = step_req;
		prev_step_ack = step_ack;
		prev_pixel = pixel;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout after %0d cycles without finishing the steps", timeout_cycles);
		errors++;
		report_and_finish();
	end

	initial begin
		logic [3:0] raw_turn;
		seed = 32'h0e02b678;
		errors = 0;
		checks = 0;
		x_wraps = 0;
		y_wraps = 0;
		reset_n = 1'b0;
		step_req = 1'b0;
		turn = snake_ctrl_pkg::heading_right;
		pixel_ack = 1'b0;
		model_heading = 4'b0001;
		for (int i = 0; i < 5; i++) begin
			body_x[i] = 24 - i;
			body_y[i] = 20;
		end
		repeat (16) @(negedge clock);
		compare_field("step_ack", step_ack, 0);
		compare_field("pixel_req", pixel_req, 0);
		reset_n = 1'b1;

		// initial body is drawn from the tail to the head
		while (received.size() < 5) @(negedge clock);
		for (int i = 0; i < 5; i++) begin
			check_pixel(received[i], 20 + i, 20, 2);
		end
		received.delete();
		compare_field("heading", heading, 4'b0001);

		for (int n = 0; n < step_count; n++) begin
			raw_turn = 4'($random(seed));
			// long runs left then up so both axes cross their wrap point
			if (n >= 40 && n < 110) begin
				raw_turn = (model_heading == 4'b0001) ? 4'b0100 : 4'b1000;
			end else if (n >= 110 && n < 180) begin
				raw_turn = (model_heading == 4'b0010) ? 4'b1000 : 4'b0100;
			end
			run_step(n, raw_turn);
		end

		checks++;
		assert (x_wraps > 0) else begin
			$display("head never wrapped in x during the step sequence");
			errors++;
		end
		checks++;
		assert (y_wraps > 0) else begin
			$display("head never wrapped in y during the step sequence");
			errors++;
		end
		report_and_finish();
	end

endmodule

`default_nettype wire

// ==== verilog/body_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module body_sequencer (
	input logic clock,
	input logic reset_n,
	input logic shift_req,
	output logic shift_ack,
	input snake_ctrl_pkg::heading_t heading,
	output logic turn_sample,
	output logic body_ready,
	output snake_geom_pkg::point_t head_point,
	output snake_geom_pkg::point_t tail_point
);

	snake_ctrl_pkg::body_state_t state;
	logic [snake_geom_pkg::index_width-1:0] index;
	logic [snake_geom_pkg::x_width-1:0] init_offset;
	snake_geom_pkg::point_t init_point;
	snake_geom_pkg::point_t next_head;
	snake_geom_pkg::point_t hold;
	logic [snake_geom_pkg::index_width-1:0] ram_address;
	logic ram_write_enable;
	snake_geom_pkg::point_t ram_write_data;
	snake_geom_pkg::point_t ram_read_data;

	segment_ram segment_ram_i (
		.clock(clock),
		.address(ram_address),
		.write_enable(ram_write_enable),
		.write_data(ram_write_data),
		.read_data(ram_read_data)
	);

	assign turn_sample = (state == snake_ctrl_pkg::body_turn);
	assign shift_ack = (state == snake_ctrl_pkg::body_ack);
	assign body_ready = (state == snake_ctrl_pkg::body_idle);

	// initial layout, x steps down by one per index
	assign init_offset = {{(snake_geom_pkg::x_width - snake_geom_pkg::index_width){1'b0}}, index};
	assign init_point.x = snake_geom_pkg::start_head.x - init_offset;
	assign init_point.y = snake_geom_pkg::start_head.y;

	always_comb begin
		next_head = head_point;
		case (heading)
			snake_ctrl_pkg::heading_right: next_head.x = head_point.x + 1'b1;
			snake_ctrl_pkg::heading_left: next_head.x = head_point.x - 1'b1;
			snake_ctrl_pkg::heading_down: next_head.y = head_point.y + 1'b1;
			snake_ctrl_pkg::heading_up: next_head.y = head_point.y - 1'b1;
			default: next_head = head_point;
		endcase
	end

	// memory port, read address defaults to the current index
	always_comb begin
		ram_address = index;
		ram_write_enable = 1'b0;
		ram_write_data = hold;
		case (state)
			snake_ctrl_pkg::body_init: begin
				ram_write_enable = 1'b1;
				ram_write_data = init_point;
			end
			snake_ctrl_pkg::body_write: begin
				ram_address = index + 1'b1;
				ram_write_enable = 1'b1;
			end
			snake_ctrl_pkg::body_head: begin
				ram_address = '0;
				ram_write_enable = 1'b1;
				ram_write_data = next_head;
			end
			default: ram_write_enable = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			state <= snake_ctrl_pkg::body_init;
			index <= '0;
		end else begin
			case (state)
				snake_ctrl_pkg::body_init: begin
					if (index == snake_geom_pkg::tail_index) begin
						state <= snake_ctrl_pkg::body_idle;
					end else begin
						index <= index + 1'b1;
					end
				end
				snake_ctrl_pkg::body_idle: begin
					if (shift_req) begin
						state <= snake_ctrl_pkg::body_turn;
					end
				end
				snake_ctrl_pkg::body_turn: begin
					// start at the segment in front of the tail
					index <= snake_geom_pkg::tail_index - 1'b1;
					state <= snake_ctrl_pkg::body_read;
				end
				snake_ctrl_pkg::body_read: state <= snake_ctrl_pkg::body_latch;
				snake_ctrl_pkg::body_latch: state <= snake_ctrl_pkg::body_write;
				snake_ctrl_pkg::body_write: begin
					if (index == '0) begin
						state <= snake_ctrl_pkg::body_head;
					end else begin
						index <= index - 1'b1;
						state <= snake_ctrl_pkg::body_read;
					end
				end
				snake_ctrl_pkg::body_head: state <= snake_ctrl_pkg::body_ack;
				snake_ctrl_pkg::body_ack: begin
					if (!shift_req) begin
						state <= snake_ctrl_pkg::body_idle;
					end
				end
				default: state <= snake_ctrl_pkg::body_init;
			endcase
		end
	end

	// head and tail copies, valid while body_ready is high
	always_ff @(posedge clock) begin
		if (state == snake_ctrl_pkg::body_init && index == snake_geom_pkg::tail_index) begin
			head_point <= snake_geom_pkg::start_head;
			tail_point <= snake_geom_pkg::start_tail;
		end
		if (state == snake_ctrl_pkg::body_latch) begin
			hold <= ram_read_data;
			// segment moving into the tail slot
			if (index == snake_geom_pkg::tail_index - 1'b1) begin
				tail_point <= ram_read_data;
			end
		end
		if (state == snake_ctrl_pkg::body_head) begin
			head_point <= next_head;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/heading_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module heading_control (
	input logic clock,
	input logic reset_n,
	input snake_ctrl_pkg::heading_t turn,
	input logic turn_sample,
	output snake_ctrl_pkg::heading_t heading
);

	logic moving_horizontal;
	logic turn_vertical;
	logic turn_horizontal;
	logic turn_allowed;

	assign moving_horizontal = (heading == snake_ctrl_pkg::heading_right) ||
		(heading == snake_ctrl_pkg::heading_left);

	// non one-hot codes match neither group
	assign turn_vertical = (turn == snake_ctrl_pkg::heading_up) ||
		(turn == snake_ctrl_pkg::heading_down);
	assign turn_horizontal = (turn == snake_ctrl_pkg::heading_right) ||
		(turn == snake_ctrl_pkg::heading_left);

	// only a right angle turn is taken
	assign turn_allowed = moving_horizontal ? turn_vertical : turn_horizontal;

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			heading <= snake_ctrl_pkg::heading_reset;
		end else if (turn_sample && turn_allowed) begin
			heading <= turn;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/plot_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module plot_sequencer (
	input logic clock,
	input logic reset_n,
	input logic step_req,
	output logic step_ack,
	input logic body_ready,
	input snake_geom_pkg::point_t head_point,
	input snake_geom_pkg::point_t tail_point,
	output logic shift_req,
	input logic shift_ack,
	output snake_ctrl_pkg::pixel_t pixel,
	output logic pixel_req,
	input logic pixel_ack
);

	snake_ctrl_pkg::plot_state_t state;
	snake_ctrl_pkg::plot_state_t next_state;
	logic [snake_geom_pkg::index_width-1:0] x_offset;
	snake_geom_pkg::point_t init_point;

	assign pixel_req = (state == snake_ctrl_pkg::plot_init_send) ||
		(state == snake_ctrl_pkg::plot_erase_send) ||
		(state == snake_ctrl_pkg::plot_head_send);
	assign shift_req = (state == snake_ctrl_pkg::plot_shift_wait);
	assign step_ack = (state == snake_ctrl_pkg::plot_step_done);

	// initial drawing walks from the tail toward the head
	assign init_point.x = tail_point.x +
		{{(snake_geom_pkg::x_width - snake_geom_pkg::index_width){1'b0}}, x_offset};
	assign init_point.y = tail_point.y;

	always_comb begin
		next_state = state;
		case (state)
			snake_ctrl_pkg::plot_start:
				if (body_ready) next_state = snake_ctrl_pkg::plot_init_send;
			snake_ctrl_pkg::plot_init_send:
				if (pixel_ack) next_state = snake_ctrl_pkg::plot_init_release;
			snake_ctrl_pkg::plot_init_release:
				// last initial pixel is the head
				if (!pixel_ack) next_state = (pixel.point == head_point) ?
					snake_ctrl_pkg::plot_idle : snake_ctrl_pkg::plot_init_send;
			snake_ctrl_pkg::plot_idle:
				if (step_req) next_state = snake_ctrl_pkg::plot_erase_send;
			snake_ctrl_pkg::plot_erase_send:
				if (pixel_ack) next_state = snake_ctrl_pkg::plot_erase_release;
			snake_ctrl_pkg::plot_erase_release:
				if (!pixel_ack) next_state = snake_ctrl_pkg::plot_shift_wait;
			snake_ctrl_pkg::plot_shift_wait:
				if (shift_ack) next_state = snake_ctrl_pkg::plot_shift_release;
			snake_ctrl_pkg::plot_shift_release:
				if (!shift_ack) next_state = snake_ctrl_pkg::plot_head_send;
			snake_ctrl_pkg::plot_head_send:
				if (pixel_ack) next_state = snake_ctrl_pkg::plot_head_release;
			snake_ctrl_pkg::plot_head_release:
				if (!pixel_ack) next_state = snake_ctrl_pkg::plot_step_done;
			snake_ctrl_pkg::plot_step_done:
				if (!step_req) next_state = snake_ctrl_pkg::plot_idle;
			default: next_state = snake_ctrl_pkg::plot_start;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			state <= snake_ctrl_pkg::plot_start;
			x_offset <= '0;
		end else begin
			state <= next_state;
			if (state == snake_ctrl_pkg::plot_init_send && pixel_ack) begin
				x_offset <= x_offset + 1'b1;
			end
		end
	end

	// pixel loads on entry to a send state and holds until the ack
	always_ff @(posedge clock) begin
		if (next_state != state) begin
			case (next_state)
				snake_ctrl_pkg::plot_init_send:
					pixel <= '{point: init_point, colour: snake_geom_pkg::colour_snake};
				snake_ctrl_pkg::plot_erase_send:
					pixel <= '{point: tail_point, colour: snake_geom_pkg::colour_blank};
				snake_ctrl_pkg::plot_head_send:
					pixel <= '{point: head_point, colour: snake_geom_pkg::colour_snake};
				default: pixel <= pixel;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/segment_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module segment_ram (
	input logic clock,
	input logic [snake_geom_pkg::index_width-1:0] address,
	input logic write_enable,
	input snake_geom_pkg::point_t write_data,
	output snake_geom_pkg::point_t read_data
);

	// one point per body segment
	snake_geom_pkg::point_t mem [snake_geom_pkg::body_length];

	always_ff @(posedge clock) begin
		if (write_enable) begin
			mem[address] <= write_data;
		end
		// registered read, old contents on a write cycle
		read_data <= mem[address];
	end

endmodule

`default_nettype wire

// ==== verilog/snake_ctrl_pkg.sv ====
`default_nettype none

package snake_ctrl_pkg;

	// one-hot headings, bit 0 right, bit 1 down, bit 2 up, bit 3 left
	typedef enum logic [3:0] {
		heading_right = 4'b0001,
		heading_down  = 4'b0010,
		heading_up    = 4'b0100,
		heading_left  = 4'b1000
	} heading_t;

	localparam heading_t heading_reset = heading_right;

	typedef enum logic [2:0] {
		body_init, body_idle, body_turn, body_read,
		body_latch, body_write, body_head, body_ack
	} body_state_t;

	typedef enum logic [3:0] {
		plot_start, plot_init_send, plot_init_release, plot_idle,
		plot_erase_send, plot_erase_release, plot_shift_wait, plot_shift_release,
		plot_head_send, plot_head_release, plot_step_done
	} plot_state_t;

	typedef struct packed {
		snake_geom_pkg::point_t point;
		snake_geom_pkg::colour_t colour;
	} pixel_t;

endpackage

`default_nettype wire

// ==== verilog/snake_geom_pkg.sv ====
`default_nettype none

package snake_geom_pkg;

	// screen coordinate widths, coordinates wrap at these widths
	localparam int x_width = 8;
	localparam int y_width = 7;

	typedef struct packed {
		logic [x_width-1:0] x;
		logic [y_width-1:0] y;
	} point_t;

	localparam int body_length = 5;
	localparam int index_width = 3;

	// index of the last segment, head sits at index 0
	localparam logic [index_width-1:0] tail_index = 3'd4;

	// initial body is a horizontal run from the tail up to the head
	localparam point_t start_head = '{x: 8'd24, y: 7'd20};
	localparam point_t start_tail = '{x: 8'd20, y: 7'd20};

	typedef logic [2:0] colour_t;

	localparam colour_t colour_blank = 3'd0;
	localparam colour_t colour_snake = 3'd2;

endpackage

`default_nettype wire

// ==== verilog/snake_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module snake_top (
	input logic clock,
	input logic reset_n,
	input logic step_req,
	output logic step_ack,
	input snake_ctrl_pkg::heading_t turn,
	output snake_ctrl_pkg::heading_t heading,
	output snake_ctrl_pkg::pixel_t pixel,
	output logic pixel_req,
	input logic pixel_ack
);

	logic turn_sample;
	logic body_ready;
	logic shift_req;
	logic shift_ack;
	snake_geom_pkg::point_t head_point;
	snake_geom_pkg::point_t tail_point;

	heading_control heading_control_i (
		.clock(clock),
		.reset_n(reset_n),
		.turn(turn),
		.turn_sample(turn_sample),
		.heading(heading)
	);

	body_sequencer body_sequencer_i (
		.clock(clock),
		.reset_n(reset_n),
		.shift_req(shift_req),
		.shift_ack(shift_ack),
		.heading(heading),
		.turn_sample(turn_sample),
		.body_ready(body_ready),
		.head_point(head_point),
		.tail_point(tail_point)
	);

	plot_sequencer plot_sequencer_i (
		.clock(clock),
		.reset_n(reset_n),
		.step_req(step_req),
		.step_ack(step_ack),
		.body_ready(body_ready),
		.head_point(head_point),
		.tail_point(tail_point),
		.shift_req(shift_req),
		.shift_ack(shift_ack),
		.pixel(pixel),
		.pixel_req(pixel_req),
		.pixel_ack(pixel_ack)
	);

endmodule

`default_nettype wire
